//--- hw/rv_isa_pkg.sv
package rv_isa_pkg;

	// Architectural widths
	typedef logic [31:0] xlen_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [11:0] csr_addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;

	// Major opcodes, bits 6:0
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_SYSTEM = 7'b1110011;

	// Branch funct3
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// Integer ALU funct3, shared by OP and OP-IMM
	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_SLL     = 3'b001;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_SLTU    = 3'b011;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_SRL_SRA = 3'b101;
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;

	// funct7 variants, ALT picks SUB and SRA
	localparam funct7_t F7_ZERO = 7'b0000000;
	localparam funct7_t F7_ALT  = 7'b0100000;

	// SYSTEM funct3 and the one legal PRIV word
	localparam funct3_t F3_PRIV  = 3'b000;
	localparam funct3_t F3_CSRRW = 3'b001;
	localparam funct3_t F3_CSRRS = 3'b010;
	localparam inst_t   INST_ECALL = 32'h0000_0073;

	// Machine CSRs kept by execute
	localparam csr_addr_t CSR_MTVEC    = 12'h305;
	localparam csr_addr_t CSR_MSCRATCH = 12'h340;
	localparam csr_addr_t CSR_MEPC     = 12'h341;
	localparam csr_addr_t CSR_MCAUSE   = 12'h342;

	// Environment call from M-mode
	localparam xlen_t MCAUSE_ECALL_M = 32'h0000_000b;

endpackage

//--- hw/rv_pipe_pkg.sv
package rv_pipe_pkg;

	// ALU function, PASS2 forwards source 2 untouched
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS2
	} alu_op_e;

	// ALU source 1
	typedef enum logic [1:0] {
		SRC1_ZERO,
		SRC1_REG1,
		SRC1_PC
	} src1_sel_e;

	// ALU source 2
	typedef enum logic [1:0] {
		SRC2_ZERO,
		SRC2_REG2,
		SRC2_IMM,
		SRC2_FOUR
	} src2_sel_e;

	// Control transfer kind
	typedef enum logic [3:0] {
		BR_NONE,
		BR_BEQ,
		BR_BNE,
		BR_BLT,
		BR_BGE,
		BR_BLTU,
		BR_BGEU,
		BR_JAL,
		BR_JALR
	} branch_e;

	// CSR side effect
	typedef enum logic [1:0] {
		CSR_NONE,
		CSR_RW,
		CSR_RS,
		CSR_ECALL
	} csr_op_e;

	// Decode stage register content
	typedef struct packed {
		rv_isa_pkg::xlen_t     pc;
		rv_isa_pkg::reg_idx_t  rs1;
		rv_isa_pkg::reg_idx_t  rs2;
		rv_isa_pkg::reg_idx_t  rd;
		logic                  we;
		rv_isa_pkg::xlen_t     imm;
		alu_op_e               alu_op;
		src1_sel_e             src1_sel;
		src2_sel_e             src2_sel;
		branch_e               branch;
		csr_op_e               csr_op;
		rv_isa_pkg::csr_addr_t csr_addr;
		logic                  illegal;
	} dec_op_t;

	// One record per retired instruction
	typedef struct packed {
		rv_isa_pkg::xlen_t    pc;
		rv_isa_pkg::reg_idx_t rd;
		logic                 we;
		rv_isa_pkg::xlen_t    result;
		logic                 branch_taken;
		rv_isa_pkg::xlen_t    branch_target;
		logic                 trap;
		rv_isa_pkg::xlen_t    cause;
		logic                 illegal;
	} retire_t;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  rv_isa_pkg::reg_idx_t rs1_i,
	input  rv_isa_pkg::reg_idx_t rs2_i,
	output rv_isa_pkg::xlen_t    rdata1_o,
	output rv_isa_pkg::xlen_t    rdata2_o,
	input  logic                 we_i,
	input  rv_isa_pkg::reg_idx_t wa_i,
	input  rv_isa_pkg::xlen_t    wd_i
);

	rv_isa_pkg::xlen_t regs_q [32];

	// Whole file cleared on reset, x0 never written
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && wa_i != '0) begin
			regs_q[wa_i] <= wd_i;
		end
	end

	// Asynchronous reads; old value on a same-cycle write
	assign rdata1_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
	assign rdata2_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

//--- hw/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
	input  rv_isa_pkg::xlen_t    src1_i,
	input  rv_isa_pkg::xlen_t    src2_i,
	input  rv_pipe_pkg::alu_op_e op_i,
	output rv_isa_pkg::xlen_t    result_o,
	output logic                 zero_o,
	output logic                 less_o
);

	logic       lt_s;
	logic       lt_u;
	logic [4:0] shamt;

	assign lt_s  = $signed(src1_i) < $signed(src2_i);
	assign lt_u  = src1_i < src2_i;
	// RV32 shifts use the low five bits only
	assign shamt = src2_i[4:0];

	always_comb begin
		case (op_i)
			rv_pipe_pkg::ALU_ADD:   result_o = src1_i + src2_i;
			rv_pipe_pkg::ALU_SUB:   result_o = src1_i - src2_i;
			rv_pipe_pkg::ALU_SLL:   result_o = src1_i << shamt;
			rv_pipe_pkg::ALU_SLT:   result_o = {31'b0, lt_s};
			rv_pipe_pkg::ALU_SLTU:  result_o = {31'b0, lt_u};
			rv_pipe_pkg::ALU_XOR:   result_o = src1_i ^ src2_i;
			rv_pipe_pkg::ALU_SRL:   result_o = src1_i >> shamt;
			rv_pipe_pkg::ALU_SRA:   result_o = $unsigned($signed(src1_i) >>> shamt);
			rv_pipe_pkg::ALU_OR:    result_o = src1_i | src2_i;
			rv_pipe_pkg::ALU_AND:   result_o = src1_i & src2_i;
			default:                result_o = src2_i;
		endcase
	end

	// Zero after SUB means equal
	assign zero_o = (result_o == '0);
	// Unsigned compare only when SLTU is requested
	assign less_o = (op_i == rv_pipe_pkg::ALU_SLTU) ? lt_u : lt_s;

endmodule

//--- hw/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 inst_valid_i,
	output logic                 inst_ready_o,
	input  rv_isa_pkg::inst_t    inst_i,
	input  rv_isa_pkg::xlen_t    pc_i,
	output logic                 dec_valid_o,
	input  logic                 dec_ready_i,
	output rv_pipe_pkg::dec_op_t dec_o
);

	rv_isa_pkg::opcode_t  opcode;
	rv_isa_pkg::funct3_t  funct3;
	rv_isa_pkg::funct7_t  funct7;
	rv_isa_pkg::xlen_t    imm_i, imm_b, imm_u, imm_j;
	rv_pipe_pkg::alu_op_e alu_f3;
	logic                 f7_ok;
	rv_pipe_pkg::dec_op_t dec_d;
	logic                 valid_q;
	rv_pipe_pkg::dec_op_t dec_q;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	// Sign-extended immediates, no S form since stores are out
	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'b0};
	assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	// ALT funct7 only legal on ADD/SUB and SRL/SRA slots
	assign f7_ok = (funct7 == rv_isa_pkg::F7_ZERO) ||
		((funct7 == rv_isa_pkg::F7_ALT) &&
		((funct3 == rv_isa_pkg::F3_ADD_SUB) || (funct3 == rv_isa_pkg::F3_SRL_SRA)));

	// funct3 to ALU op; SUB only exists on OP, not OP-IMM
	always_comb begin
		case (funct3)
			rv_isa_pkg::F3_ADD_SUB: alu_f3 = (opcode == rv_isa_pkg::OPC_OP &&
				funct7 == rv_isa_pkg::F7_ALT) ? rv_pipe_pkg::ALU_SUB : rv_pipe_pkg::ALU_ADD;
			rv_isa_pkg::F3_SLL:     alu_f3 = rv_pipe_pkg::ALU_SLL;
			rv_isa_pkg::F3_SLT:     alu_f3 = rv_pipe_pkg::ALU_SLT;
			rv_isa_pkg::F3_SLTU:    alu_f3 = rv_pipe_pkg::ALU_SLTU;
			rv_isa_pkg::F3_XOR:     alu_f3 = rv_pipe_pkg::ALU_XOR;
			rv_isa_pkg::F3_SRL_SRA: alu_f3 = (funct7 == rv_isa_pkg::F7_ALT) ?
				rv_pipe_pkg::ALU_SRA : rv_pipe_pkg::ALU_SRL;
			rv_isa_pkg::F3_OR:      alu_f3 = rv_pipe_pkg::ALU_OR;
			default:                alu_f3 = rv_pipe_pkg::ALU_AND;
		endcase
	end

	always_comb begin
		// Defaults describe a harmless no-write op
		dec_d          = '0;
		dec_d.pc       = pc_i;
		dec_d.rs1      = inst_i[19:15];
		dec_d.rs2      = inst_i[24:20];
		dec_d.rd       = inst_i[11:7];
		dec_d.imm      = imm_i;
		dec_d.alu_op   = rv_pipe_pkg::ALU_ADD;
		dec_d.src1_sel = rv_pipe_pkg::SRC1_ZERO;
		dec_d.src2_sel = rv_pipe_pkg::SRC2_ZERO;
		dec_d.branch   = rv_pipe_pkg::BR_NONE;
		dec_d.csr_op   = rv_pipe_pkg::CSR_NONE;
		dec_d.csr_addr = inst_i[31:20];
		case (opcode)
			rv_isa_pkg::OPC_LUI: begin
				dec_d.we       = 1'b1;
				dec_d.imm      = imm_u;
				dec_d.alu_op   = rv_pipe_pkg::ALU_PASS2;
				dec_d.src2_sel = rv_pipe_pkg::SRC2_IMM;
			end
			rv_isa_pkg::OPC_AUIPC: begin
				dec_d.we       = 1'b1;
				dec_d.imm      = imm_u;
				dec_d.src1_sel = rv_pipe_pkg::SRC1_PC;
				dec_d.src2_sel = rv_pipe_pkg::SRC2_IMM;
			end
			// Jumps: ALU makes the link value PC+4
			rv_isa_pkg::OPC_JAL: begin
				dec_d.we       = 1'b1;
				dec_d.imm      = imm_j;
				dec_d.src1_sel = rv_pipe_pkg::SRC1_PC;
				dec_d.src2_sel = rv_pipe_pkg::SRC2_FOUR;
				dec_d.branch   = rv_pipe_pkg::BR_JAL;
			end
			rv_isa_pkg::OPC_JALR: begin
				dec_d.we       = 1'b1;
				dec_d.src1_sel = rv_pipe_pkg::SRC1_PC;
				dec_d.src2_sel = rv_pipe_pkg::SRC2_FOUR;
				dec_d.branch   = rv_pipe_pkg::BR_JALR;
				dec_d.illegal  = (funct3 != 3'b000);
			end
			rv_isa_pkg::OPC_BRANCH: begin
				dec_d.imm      = imm_b;
				dec_d.src1_sel = rv_pipe_pkg::SRC1_REG1;
				dec_d.src2_sel = rv_pipe_pkg::SRC2_REG2;
				case (funct3)
					rv_isa_pkg::F3_BEQ:  dec_d.branch = rv_pipe_pkg::BR_BEQ;
					rv_isa_pkg::F3_BNE:  dec_d.branch = rv_pipe_pkg::BR_BNE;
					rv_isa_pkg::F3_BLT:  dec_d.branch = rv_pipe_pkg::BR_BLT;
					rv_isa_pkg::F3_BGE:  dec_d.branch = rv_pipe_pkg::BR_BGE;
					rv_isa_pkg::F3_BLTU: dec_d.branch = rv_pipe_pkg::BR_BLTU;
					rv_isa_pkg::F3_BGEU: dec_d.branch = rv_pipe_pkg::BR_BGEU;
					default:             dec_d.illegal = 1'b1;
				endcase
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				dec_d.we       = 1'b1;
				dec_d.alu_op   = alu_f3;
				dec_d.src1_sel = rv_pipe_pkg::SRC1_REG1;
				dec_d.src2_sel = rv_pipe_pkg::SRC2_IMM;
				// Shift immediates carry funct7 in imm[11:5]
				if (funct3 == rv_isa_pkg::F3_SLL || funct3 == rv_isa_pkg::F3_SRL_SRA) begin
					dec_d.illegal = !f7_ok;
				end
			end
			rv_isa_pkg::OPC_OP: begin
				dec_d.we       = 1'b1;
				dec_d.alu_op   = alu_f3;
				dec_d.src1_sel = rv_pipe_pkg::SRC1_REG1;
				dec_d.src2_sel = rv_pipe_pkg::SRC2_REG2;
				dec_d.illegal  = !f7_ok;
			end
			rv_isa_pkg::OPC_SYSTEM: begin
				case (funct3)
					rv_isa_pkg::F3_PRIV: begin
						dec_d.csr_op  = rv_pipe_pkg::CSR_ECALL;
						dec_d.illegal = (inst_i != rv_isa_pkg::INST_ECALL);
					end
					rv_isa_pkg::F3_CSRRW: begin
						dec_d.we     = 1'b1;
						dec_d.csr_op = rv_pipe_pkg::CSR_RW;
					end
					rv_isa_pkg::F3_CSRRS: begin
						dec_d.we     = 1'b1;
						dec_d.csr_op = rv_pipe_pkg::CSR_RS;
					end
					default: dec_d.illegal = 1'b1;
				endcase
			end
			default: dec_d.illegal = 1'b1;
		endcase
		// Illegal ops carry no side effects downstream
		if (dec_d.illegal) begin
			dec_d.we     = 1'b0;
			dec_d.branch = rv_pipe_pkg::BR_NONE;
			dec_d.csr_op = rv_pipe_pkg::CSR_NONE;
		end
	end

	// Accept when empty or when the current op leaves this cycle
	assign inst_ready_o = !valid_q || dec_ready_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= 1'b0;
		end else if (inst_ready_o) begin
			valid_q <= inst_valid_i;
		end
	end

	// Stage payload
	always_ff @(posedge clk_i) begin
		if (inst_valid_i && inst_ready_o) begin
			dec_q <= dec_d;
		end
	end

	assign dec_valid_o = valid_q;
	assign dec_o       = dec_q;

	// Held op must not change while execute stalls
	a_dec_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_o));

endmodule

//--- hw/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 dec_valid_i,
	output logic                 dec_ready_o,
	input  rv_pipe_pkg::dec_op_t dec_i,
	output rv_isa_pkg::reg_idx_t rs1_o,
	output rv_isa_pkg::reg_idx_t rs2_o,
	input  rv_isa_pkg::xlen_t    rdata1_i,
	input  rv_isa_pkg::xlen_t    rdata2_i,
	output logic                 retire_valid_o,
	input  logic                 retire_ready_i,
	output rv_pipe_pkg::retire_t retire_o
);

	logic                 fire;
	logic                 fwd_ok;
	rv_isa_pkg::xlen_t    op1, op2;
	rv_isa_pkg::xlen_t    src1, src2;
	rv_pipe_pkg::alu_op_e alu_op;
	rv_isa_pkg::xlen_t    alu_res;
	logic                 alu_zero, alu_less;
	logic                 taken;
	rv_isa_pkg::xlen_t    target;
	rv_isa_pkg::xlen_t    mtvec_q, mscratch_q, mepc_q, mcause_q;
	rv_isa_pkg::xlen_t    csr_rdata, csr_wdata;
	logic                 csr_hit, csr_acc, csr_we, ecall;
	rv_pipe_pkg::retire_t ret_d;
	rv_pipe_pkg::retire_t ret_q;
	logic                 ret_valid_q;

	// Retire slot free or draining this cycle
	assign dec_ready_o = !ret_valid_q || retire_ready_i;
	assign fire        = dec_valid_i && dec_ready_o;

	assign rs1_o = dec_i.rs1;
	assign rs2_o = dec_i.rs2;

	// Only the retire slot can hold an unwritten result
	assign fwd_ok = ret_valid_q && ret_q.we && ret_q.rd != '0;
	assign op1 = (fwd_ok && ret_q.rd == dec_i.rs1) ? ret_q.result : rdata1_i;
	assign op2 = (fwd_ok && ret_q.rd == dec_i.rs2) ? ret_q.result : rdata2_i;

	always_comb begin
		case (dec_i.src1_sel)
			rv_pipe_pkg::SRC1_REG1: src1 = op1;
			rv_pipe_pkg::SRC1_PC:   src1 = dec_i.pc;
			default:                src1 = '0;
		endcase
		case (dec_i.src2_sel)
			rv_pipe_pkg::SRC2_REG2: src2 = op2;
			rv_pipe_pkg::SRC2_IMM:  src2 = dec_i.imm;
			rv_pipe_pkg::SRC2_FOUR: src2 = 32'd4;
			default:                src2 = '0;
		endcase
		// Conditional branches override the ALU op with a compare
		case (dec_i.branch)
			rv_pipe_pkg::BR_BEQ, rv_pipe_pkg::BR_BNE:   alu_op = rv_pipe_pkg::ALU_SUB;
			rv_pipe_pkg::BR_BLT, rv_pipe_pkg::BR_BGE:   alu_op = rv_pipe_pkg::ALU_SLT;
			rv_pipe_pkg::BR_BLTU, rv_pipe_pkg::BR_BGEU: alu_op = rv_pipe_pkg::ALU_SLTU;
			default:                                    alu_op = dec_i.alu_op;
		endcase
	end

	rv_alu u_alu (
		.src1_i   (src1),
		.src2_i   (src2),
		.op_i     (alu_op),
		.result_o (alu_res),
		.zero_o   (alu_zero),
		.less_o   (alu_less)
	);

	assign ecall = (dec_i.csr_op == rv_pipe_pkg::CSR_ECALL);

	// Branch outcome and target
	always_comb begin
		case (dec_i.branch)
			rv_pipe_pkg::BR_BEQ:                        taken = alu_zero;
			rv_pipe_pkg::BR_BNE:                        taken = !alu_zero;
			rv_pipe_pkg::BR_BLT, rv_pipe_pkg::BR_BLTU:  taken = alu_less;
			rv_pipe_pkg::BR_BGE, rv_pipe_pkg::BR_BGEU:  taken = !alu_less;
			rv_pipe_pkg::BR_JAL, rv_pipe_pkg::BR_JALR:  taken = 1'b1;
			default:                                    taken = 1'b0;
		endcase
		if (dec_i.branch == rv_pipe_pkg::BR_JALR) begin
			target = (op1 + dec_i.imm) & ~32'd1;
		end else if (dec_i.branch != rv_pipe_pkg::BR_NONE) begin
			target = dec_i.pc + dec_i.imm;
		end else if (ecall) begin
			target = mtvec_q;
		end else begin
			target = '0;
		end
	end

	// CSR read port where a miss flags an unimplemented address
	always_comb begin
		csr_hit = 1'b1;
		case (dec_i.csr_addr)
			rv_isa_pkg::CSR_MTVEC:    csr_rdata = mtvec_q;
			rv_isa_pkg::CSR_MSCRATCH: csr_rdata = mscratch_q;
			rv_isa_pkg::CSR_MEPC:     csr_rdata = mepc_q;
			rv_isa_pkg::CSR_MCAUSE:   csr_rdata = mcause_q;
			default: begin
				csr_rdata = '0;
				csr_hit   = 1'b0;
			end
		endcase
	end

	assign csr_acc   = (dec_i.csr_op == rv_pipe_pkg::CSR_RW) ||
		(dec_i.csr_op == rv_pipe_pkg::CSR_RS);
	assign csr_wdata = (dec_i.csr_op == rv_pipe_pkg::CSR_RW) ? op1 : (op1 | csr_rdata);
	// CSRRS with x0 is a pure read
	assign csr_we    = csr_hit && ((dec_i.csr_op == rv_pipe_pkg::CSR_RW) ||
		(dec_i.csr_op == rv_pipe_pkg::CSR_RS && dec_i.rs1 != '0));

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mtvec_q    <= '0;
			mscratch_q <= '0;
			mepc_q     <= '0;
			mcause_q   <= '0;
		end else if (fire && ecall) begin
			mepc_q   <= dec_i.pc;
			mcause_q <= rv_isa_pkg::MCAUSE_ECALL_M;
		end else if (fire && csr_we) begin
			case (dec_i.csr_addr)
				rv_isa_pkg::CSR_MTVEC:    mtvec_q    <= csr_wdata;
				rv_isa_pkg::CSR_MSCRATCH: mscratch_q <= csr_wdata;
				rv_isa_pkg::CSR_MEPC:     mepc_q     <= csr_wdata;
				default:                  mcause_q   <= csr_wdata;
			endcase
		end
	end

	// Build the retire record
	always_comb begin
		ret_d.pc            = dec_i.pc;
		ret_d.rd            = dec_i.rd;
		ret_d.illegal       = dec_i.illegal || (csr_acc && !csr_hit);
		// Decode already clears we for its own illegal flag
		ret_d.we            = dec_i.we && !(csr_acc && !csr_hit);
		ret_d.result        = csr_acc ? csr_rdata : alu_res;
		ret_d.branch_taken  = taken;
		ret_d.branch_target = target;
		ret_d.trap          = ecall;
		ret_d.cause         = ecall ? rv_isa_pkg::MCAUSE_ECALL_M : '0;
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ret_valid_q <= 1'b0;
		end else if (dec_ready_o) begin
			ret_valid_q <= dec_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (fire) begin
			ret_q <= ret_d;
		end
	end

	assign retire_valid_o = ret_valid_q;
	assign retire_o       = ret_q;

	// Stalled record held until the sink takes it
	a_ret_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		retire_valid_o && !retire_ready_i |=> retire_valid_o && $stable(retire_o));

	// No register write ever leaves with an illegal record
	a_ill_no_we: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		retire_valid_o && retire_o.illegal |-> !retire_o.we);

endmodule

//--- hw/rv_exec_core.sv
`timescale 1ns/1ps

module rv_exec_core (
	input  logic                 clk_i,
	input  logic                 arst_n_i,
	input  logic                 inst_valid_i,
	output logic                 inst_ready_o,
	input  rv_isa_pkg::inst_t    inst_i,
	input  rv_isa_pkg::xlen_t    pc_i,
	output logic                 retire_valid_o,
	input  logic                 retire_ready_i,
	output rv_pipe_pkg::retire_t retire_o
);

	// Decode to execute stream
	logic                 dec_valid;
	logic                 dec_ready;
	rv_pipe_pkg::dec_op_t dec_op;

	// Register file ports
	rv_isa_pkg::reg_idx_t rs1, rs2;
	rv_isa_pkg::xlen_t    rdata1, rdata2;
	logic                 rf_we;

	rv_decode u_decode (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.inst_valid_i (inst_valid_i),
		.inst_ready_o (inst_ready_o),
		.inst_i       (inst_i),
		.pc_i         (pc_i),
		.dec_valid_o  (dec_valid),
		.dec_ready_i  (dec_ready),
		.dec_o        (dec_op)
	);

	// Write lands only when the record is handed over
	assign rf_we = retire_valid_o && retire_ready_i && retire_o.we;

	rv_regfile u_regfile (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.rs1_i    (rs1),
		.rs2_i    (rs2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.we_i     (rf_we),
		.wa_i     (retire_o.rd),
		.wd_i     (retire_o.result)
	);

	rv_execute u_execute (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.dec_valid_i    (dec_valid),
		.dec_ready_o    (dec_ready),
		.dec_i          (dec_op),
		.rs1_o          (rs1),
		.rs2_o          (rs2),
		.rdata1_i       (rdata1),
		.rdata2_i       (rdata2),
		.retire_valid_o (retire_valid_o),
		.retire_ready_i (retire_ready_i),
		.retire_o       (retire_o)
	);

endmodule

//--- bench/rv_exec_core_tb.sv
`timescale 1ns/1ps

module rv_exec_core_tb;

	logic                 clk_i;
	logic                 arst_n_i;
	logic                 inst_valid_i;
	logic                 inst_ready_o;
	rv_isa_pkg::inst_t    inst_i;
	rv_isa_pkg::xlen_t    pc_i;
	logic                 retire_valid_o;
	logic                 retire_ready_i;
	rv_pipe_pkg::retire_t retire_o;

	// Test vectors with one entry per line of the file
	rv_isa_pkg::inst_t    inst_q[$];
	rv_pipe_pkg::retire_t exp_q[$];

	int     n_tests  = 0;
	int     feed_idx = 0;
	int     chk_idx  = 0;
	int     pass_cnt = 0;
	int     fail_cnt = 0;
	int     misc_err = 0;
	logic   loaded   = 1'b0;
	integer seed     = 10;

	rv_exec_core dut_i (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.inst_valid_i   (inst_valid_i),
		.inst_ready_o   (inst_ready_o),
		.inst_i         (inst_i),
		.pc_i           (pc_i),
		.retire_valid_o (retire_valid_o),
		.retire_ready_i (retire_ready_i),
		.retire_o       (retire_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// File columns are inst pc rd we result taken target trap illegal
	task automatic load_tests();
		int                   fd;
		int                   cnt;
		logic [8*160-1:0]     line;
		logic [31:0]          v_inst, v_pc, v_rd, v_we, v_res;
		logic [31:0]          v_tk, v_tgt, v_trap, v_ill;
		rv_pipe_pkg::retire_t rec;
		fd = $fopen("bench/rv_exec_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open bench/rv_exec_tests.txt for reading");
		end else begin
			while ($fgets(line, fd) != 0) begin
				cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
					v_inst, v_pc, v_rd, v_we, v_res, v_tk, v_tgt, v_trap, v_ill);
				// Comment lines do not scan as nine fields
				if (cnt == 9) begin
					rec               = '0;
					rec.pc            = v_pc;
					rec.rd            = v_rd[4:0];
					rec.we            = v_we[0];
					rec.result        = v_res;
					rec.branch_taken  = v_tk[0];
					rec.branch_target = v_tgt;
					rec.trap          = v_trap[0];
					// ECALL from M-mode is the only trap source and has cause 0xb
					rec.cause         = v_trap[0] ? 32'h0000_000b : 32'h0000_0000;
					rec.illegal       = v_ill[0];
					inst_q.push_back(v_inst);
					exp_q.push_back(rec);
				end
			end
			$fclose(fd);
		end
		n_tests = exp_q.size();
		loaded  = 1'b1;
	endtask

	task automatic compare_field(input int idx, input string name, input logic [31:0] got,
		input logic [31:0] exp, inout int bad);
		if (got !== exp) begin
			$display("[FAIL] test %0d %s got %h expected %h", idx, name, got, exp);
			bad++;
		end
	endtask

	task automatic check_record(input int idx, input rv_pipe_pkg::retire_t got);
		rv_pipe_pkg::retire_t exp;
		int                   bad;
		exp = exp_q[idx];
		bad = 0;
		compare_field(idx, "retire_o.pc", got.pc, exp.pc, bad);
		compare_field(idx, "retire_o.we", got.we, exp.we, bad);
		compare_field(idx, "retire_o.illegal", got.illegal, exp.illegal, bad);
		compare_field(idx, "retire_o.trap", got.trap, exp.trap, bad);
		compare_field(idx, "retire_o.cause", got.cause, exp.cause, bad);
		compare_field(idx, "retire_o.branch_taken", got.branch_taken, exp.branch_taken, bad);
		// Destination only meaningful on a register write
		if (exp.we) begin
			compare_field(idx, "retire_o.rd", got.rd, exp.rd, bad);
			compare_field(idx, "retire_o.result", got.result, exp.result, bad);
		end
		// Target only meaningful when control leaves the sequence
		if (exp.branch_taken || exp.trap) begin
			compare_field(idx, "retire_o.branch_target", got.branch_target,
				exp.branch_target, bad);
		end
		if (bad == 0) begin
			$display("[PASS] test %0d pc %h", idx, got.pc);
			pass_cnt++;
		end else begin
			fail_cnt++;
		end
	endtask

	task automatic run_tests();
		repeat (5) @(posedge clk_i);
		@(negedge clk_i);
		arst_n_i = 1'b1;
		while (chk_idx < n_tests) begin
			@(negedge clk_i);
			// Sink always ready for the first half and random after
			if (chk_idx >= n_tests / 2) begin
				retire_ready_i = ($random(seed) % 4) != 0;
			end else begin
				retire_ready_i = 1'b1;
			end
			// Hold the current instruction until accepted
			if (feed_idx < n_tests) begin
				inst_valid_i = 1'b1;
				inst_i       = inst_q[feed_idx];
				pc_i         = exp_q[feed_idx].pc;
			end else begin
				inst_valid_i = 1'b0;
			end
			#1;
			// Handshakes seen here complete at the next rising edge
			if (retire_valid_o && retire_ready_i) begin
				check_record(chk_idx, retire_o);
				chk_idx++;
			end
			if (inst_valid_i && inst_ready_o) begin
				feed_idx++;
			end
		end
		// Pipeline must be empty once every record is in
		@(negedge clk_i);
		inst_valid_i   = 1'b0;
		retire_ready_i = 1'b1;
		repeat (4) begin
			#1;
			if (retire_valid_o) begin
				$display("An extra retire record arrived after the last expected one");
				misc_err++;
			end
			@(negedge clk_i);
		end
	endtask

	initial begin
		arst_n_i       = 1'b0;
		inst_valid_i   = 1'b0;
		inst_i         = '0;
		pc_i           = '0;
		retire_ready_i = 1'b0;
		load_tests();
		if (n_tests == 0) begin
			$display("No test vectors were read from the test file");
		end else begin
			run_tests();
		end
		$display("Tests %0d, passed %0d, failed %0d, other errors %0d",
			n_tests, pass_cnt, fail_cnt, misc_err);
		if (n_tests > 0 && fail_cnt == 0 && misc_err == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Budget of 40 cycles per test plus reset
	initial begin
		wait (loaded);
		repeat (n_tests * 40 + 5) @(posedge clk_i);
		$display("Timeout, only %0d of %0d records retired", chk_idx, n_tests);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- bench/rv_exec_tests.txt
# inst     pc       rd we result   taken target   trap illegal
# All hex; rd and result checked only when we is 1, target only when taken or trap
00500093 00000100 01 1 00000005 0 00000000 0 0
00708093 00000104 01 1 0000000c 0 00000000 0 0
fff08113 00000108 02 1 0000000b 0 00000000 0 0
002081b3 0000010c 03 1 00000017 0 00000000 0 0
40110233 00000110 04 1 ffffffff 0 00000000 0 0
800002b7 00000114 05 1 80000000 0 00000000 0 0
00001317 00000118 06 1 00001118 0 00000000 0 0
4042d393 0000011c 07 1 f8000000 0 00000000 0 0
0042d413 00000120 08 1 08000000 0 00000000 0 0
001224b3 00000124 09 1 00000001 0 00000000 0 0
00123533 00000128 0a 1 00000000 0 00000000 0 0
0ff0c593 0000012c 0b 1 000000f3 0 00000000 0 0
01c09613 00000130 0c 1 c0000000 0 00000000 0 0
00c5e6b3 00000134 0d 1 c00000f3 0 00000000 0 0
fff6f013 00000138 00 1 c00000f3 0 00000000 0 0
00100733 0000013c 0e 1 0000000c 0 00000000 0 0
00108863 00000140 00 0 00000000 1 00000150 0 0
fe109ce3 00000144 00 0 00000000 0 00000000 0 0
00124863 00000148 00 0 00000000 1 00000158 0 0
00126863 0000014c 00 0 00000000 0 00000000 0 0
fe82dce3 00000150 00 0 00000000 0 00000000 0 0
fe82fce3 00000154 00 0 00000000 1 0000014c 0 0
0010d863 00000158 00 0 00000000 1 00000168 0 0
00521863 0000015c 00 0 00000000 1 0000016c 0 0
020007ef 00000160 0f 1 00000164 1 00000180 0 0
00378867 00000164 10 1 00000168 1 00000166 0 0
340698f3 00000168 11 1 00000000 0 00000000 0 0
3400a973 0000016c 12 1 c00000f3 0 00000000 0 0
340029f3 00000170 13 1 c00000ff 0 00000000 0 0
30531a73 00000174 14 1 00000000 0 00000000 0 0
30502af3 00000178 15 1 00001118 0 00000000 0 0
00000073 0000017c 00 0 00000000 0 00001118 1 0
34102b73 00000180 16 1 0000017c 0 00000000 0 0
34202bf3 00000184 17 1 0000000b 0 00000000 0 0
00000003 00000188 00 0 00000000 0 00000000 0 1
30009c73 0000018c 00 0 00000000 0 00000000 0 1
02208cb3 00000190 00 0 00000000 0 00000000 0 1
001c0d13 00000194 1a 1 00000001 0 00000000 0 0
003d0db3 00000198 1b 1 00000018 0 00000000 0 0
00838e33 0000019c 1c 1 00000000 0 00000000 0 0
7ff00e93 000001a0 1d 1 000007ff 0 00000000 0 0

//--- sources.f
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_exec_core.sv
bench/rv_exec_core_tb.sv
